/* hdl/labm_pkg.sv */
/*
   Shared definitions for the ABM manager
   - Host address and AXI burst length widths
   - Host address, burst length and ABM index types
   - States of the request state machine
*/

`default_nettype none

package labm_pkg;

   // Width of an address in host RAM
   localparam int HOST_ADDR_W = 64;

   // Width of an AXI4 burst length field
   localparam int LEN_W = 8;

   // An AXI burst length holds the number of beats minus one
   typedef logic [LEN_W-1:0] labm_len_t;

   // A byte address in host RAM
   typedef logic [HOST_ADDR_W-1:0] labm_host_addr_t;

   // Selects one of the two ABM buffers
   typedef logic labm_abm_t;

   // The two master requests are acknowledged one after the other,
   // then the data of both bursts is awaited
   typedef enum logic [1:0] {
      IDLE,
      WAIT_REQ0_ACK,
      WAIT_REQ1_ACK,
      WAIT_DATA
   } labm_state_t;

endpackage

`default_nettype wire

/* hdl/labm_beat_if.sv */
/*
   Stream of read-data beats
   - Data word, last flag, valid and ready
   - Source, sink and monitor modports
*/

`timescale 1ns/100ps
`default_nettype none

interface labm_beat_if #(
   parameter int DATA_W = 32
) ();

   // A beat moves on a clock edge where valid and ready are both high
   logic [DATA_W-1:0] data;
   logic              last;
   logic              valid;
   logic              ready;

   // The source holds valid and data steady until the beat is taken
   modport source (output data, last, valid, input ready);

   modport sink (input data, last, valid, output ready);

   // Observes the handshake without taking part in it
   modport monitor (input last, valid, ready);

endinterface

`default_nettype wire

/* hdl/labm_beat_fifo.sv */
/*
   Synchronous FIFO of read-data beats
   - Circular buffer with read and write pointers and a fill count
   - Valid/ready handshake on both the input and the output side
*/

`timescale 1ns/100ps
`default_nettype none

module labm_beat_fifo #(
   parameter int DATA_W     = 32,
   parameter int FIFO_DEPTH = 256
) (
   input  wire              clk,
   input  wire              resetn,
   input  wire [DATA_W-1:0] in_data,
   input  wire              in_last,
   input  wire              in_valid,
   output logic             in_ready,
   output logic [DATA_W-1:0] out_data,
   output logic             out_last,
   output logic             out_valid,
   input  wire              out_ready
);

   // A stored beat is the last flag above the data word
   localparam int BEAT_W = DATA_W + 1;
   localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);

   logic [BEAT_W-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;
   logic              push;
   logic              pop;

   assign in_ready  = (count != CNT_W'(FIFO_DEPTH));
   assign out_valid = (count != '0);
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;

   // The head beat comes straight out of the register array
   assign {out_last, out_data} = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= {in_last, in_data};
      end
   end

   //==================================================
   // Pointers and fill count
   //==================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap at the depth, which need not be a power of two
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/labm_burst_tracker.sv */
/*
   Burst tracker of the ABM manager
   - Selects the FIFO that receives the master read beats
   - Records which of the two ABM bursts have fully arrived
*/

`timescale 1ns/100ps
`default_nettype none

module labm_burst_tracker import labm_pkg::*; (
   input  wire          clk,
   input  wire          resetn,
   input  wire          begin_burst,
   labm_beat_if.monitor beats,
   output labm_abm_t    fifo_sel,
   output logic         all_fetched
);

   // One flag per ABM, set when its burst has ended
   logic [1:0] fetched;
   logic       last_xfer;

   // The final beat of a burst is being handed over
   assign last_xfer = beats.valid && beats.ready && beats.last;

   always_ff @(posedge clk) begin
      if (!resetn || begin_burst) begin
         fifo_sel <= 1'b0;
         fetched  <= 2'b00;
      end else if (last_xfer) begin
         // Burst 1 always follows burst 0
         fifo_sel          <= 1'b1;
         fetched[fifo_sel] <= 1'b1;
      end
   end

   // High once both bursts are in the FIFOs
   assign all_fetched = &fetched;

endmodule

`default_nettype wire

/* hdl/labm_request_fsm.sv */
/*
   Request state machine of the ABM manager
   - Accepts one read request on the slave AR channel
   - Issues two master AR requests, to ABM 0 and then to ABM 1
   - Pulses begin_burst on acceptance
   - Waits for both bursts to be fetched before the next request
*/

`timescale 1ns/100ps
`default_nettype none

module labm_request_fsm import labm_pkg::*; #(
   parameter int SLV_ADDR_W = 20
) (
   input  wire                    clk,
   input  wire                    resetn,
   input  labm_host_addr_t        abm0_addr,
   input  labm_host_addr_t        abm1_addr,
   input  wire [SLV_ADDR_W-1:0]   s_araddr,
   input  labm_len_t              s_arlen,
   input  wire                    s_arvalid,
   output logic                   s_arready,
   output labm_host_addr_t        m_araddr,
   output labm_len_t              m_arlen,
   output logic                   m_arvalid,
   input  wire                    m_arready,
   input  wire                    all_fetched,
   output logic                   begin_burst
);

   labm_state_t     state;

   // Offset into the ABMs, kept for forming the second address
   labm_host_addr_t offset;

   logic            accept;
   logic            req0_done;

   // New requests are taken only while idle
   assign s_arready = (state == IDLE) && resetn;
   assign accept    = s_arvalid && s_arready;
   assign req0_done = (state == WAIT_REQ0_ACK) && m_arvalid && m_arready;

   //==================================================
   // State register and control outputs
   //==================================================
   always_ff @(posedge clk) begin
      // begin_burst is high for a single cycle at a time
      begin_burst <= 1'b0;
      if (!resetn) begin
         state     <= IDLE;
         m_arvalid <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (accept) begin
                  m_arvalid   <= 1'b1;
                  begin_burst <= 1'b1;
                  state       <= WAIT_REQ0_ACK;
               end
            end
            // ARVALID stays high across both requests
            WAIT_REQ0_ACK: begin
               if (m_arready) begin
                  state <= WAIT_REQ1_ACK;
               end
            end
            WAIT_REQ1_ACK: begin
               if (m_arready) begin
                  m_arvalid <= 1'b0;
                  state     <= WAIT_DATA;
               end
            end
            // Both bursts must be in the FIFOs before the next request
            WAIT_DATA: begin
               if (all_fetched) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   //==================================================
   // Master address and length
   //==================================================
   always_ff @(posedge clk) begin
      if (accept) begin
         offset   <= labm_host_addr_t'(s_araddr);
         m_araddr <= abm0_addr + labm_host_addr_t'(s_araddr);
         m_arlen  <= s_arlen;
      end else if (req0_done) begin
         // Same offset and length, now into ABM 1
         m_araddr <= abm1_addr + offset;
      end
   end

endmodule

`default_nettype wire

/* hdl/labm_read_merge.sv */
/*
   Read merge of the ABM manager
   - Steers master read beats into one of two beat FIFOs
   - ORs the two FIFO heads onto the slave R channel
*/

`timescale 1ns/100ps
`default_nettype none

module labm_read_merge import labm_pkg::*; #(
   parameter int DATA_W     = 32,
   parameter int FIFO_DEPTH = 256
) (
   input  wire               clk,
   input  wire               resetn,
   labm_beat_if.sink         beats,
   input  labm_abm_t         fifo_sel,
   output logic [DATA_W-1:0] s_rdata,
   output logic              s_rlast,
   output logic              s_rvalid,
   input  wire               s_rready
);

   logic              f0_in_ready;
   logic              f1_in_ready;
   logic [DATA_W-1:0] f0_data;
   logic [DATA_W-1:0] f1_data;
   logic              f0_last;
   logic              f0_valid;
   logic              f1_valid;
   logic              pop;

   // Only the selected FIFO sees the beat and answers with its ready
   assign beats.ready = fifo_sel ? f1_in_ready : f0_in_ready;

   // Both heads advance together, and only when both are present
   assign pop = s_rready && f0_valid && f1_valid;

   assign s_rvalid = f0_valid && f1_valid;
   assign s_rdata  = f0_data | f1_data;
   // Both bursts have the same length, so the last flags line up
   assign s_rlast  = f0_last;

   // Beats of the ABM 0 burst
   labm_beat_fifo #(
      .DATA_W     (DATA_W),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) fifo_0 (
      .clk       (clk),
      .resetn    (resetn),
      .in_data   (beats.data),
      .in_last   (beats.last),
      .in_valid  (beats.valid && !fifo_sel),
      .in_ready  (f0_in_ready),
      .out_data  (f0_data),
      .out_last  (f0_last),
      .out_valid (f0_valid),
      .out_ready (pop)
   );

   // Beats of the ABM 1 burst, whose last flag repeats the one of FIFO 0
   labm_beat_fifo #(
      .DATA_W     (DATA_W),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) fifo_1 (
      .clk       (clk),
      .resetn    (resetn),
      .in_data   (beats.data),
      .in_last   (beats.last),
      .in_valid  (beats.valid && fifo_sel),
      .in_ready  (f1_in_ready),
      .out_data  (f1_data),
      .out_last  (),
      .out_valid (f1_valid),
      .out_ready (pop)
   );

endmodule

`default_nettype wire

/* hdl/labm_manager.sv */
/*
   ABM manager top level
   - Slave AR and R channels of a read-only AXI4 slave
   - Master AR and R channels towards host RAM
   - Each slave read fetches the same range from ABM 0 and ABM 1
     and returns the bitwise OR of the two bursts
   - Master requests are incrementing bursts of full data words
*/

`timescale 1ns/100ps
`default_nettype none

module labm_manager import labm_pkg::*; #(
   parameter int DATA_W     = 32,
   parameter int SLV_ADDR_W = 20,
   parameter int FIFO_DEPTH = 256
) (
   input  wire                   clk,
   input  wire                   resetn,
   input  labm_host_addr_t       abm0_addr,
   input  labm_host_addr_t       abm1_addr,

   // Slave read address channel
   input  wire [SLV_ADDR_W-1:0]  s_axi_araddr,
   input  labm_len_t             s_axi_arlen,
   input  wire                   s_axi_arvalid,
   output logic                  s_axi_arready,

   // Slave read data channel
   output logic [DATA_W-1:0]     s_axi_rdata,
   output logic [1:0]            s_axi_rresp,
   output logic                  s_axi_rlast,
   output logic                  s_axi_rvalid,
   input  wire                   s_axi_rready,

   // Master read address channel
   output labm_host_addr_t       m_axi_araddr,
   output labm_len_t             m_axi_arlen,
   output logic                  m_axi_arvalid,
   input  wire                   m_axi_arready,

   // Master read data channel
   input  wire [DATA_W-1:0]      m_axi_rdata,
   input  wire                   m_axi_rlast,
   input  wire                   m_axi_rvalid,
   output logic                  m_axi_rready
);

   logic      begin_burst;
   logic      all_fetched;
   labm_abm_t fifo_sel;

   // Master R channel as a beat stream
   labm_beat_if #(.DATA_W(DATA_W)) rd_beats ();

   assign rd_beats.data  = m_axi_rdata;
   assign rd_beats.last  = m_axi_rlast;
   assign rd_beats.valid = m_axi_rvalid;
   assign m_axi_rready   = rd_beats.ready;

   // Every read answers OKAY
   assign s_axi_rresp = 2'b00;

   //==================================================
   // Request side
   //==================================================
   labm_request_fsm #(
      .SLV_ADDR_W (SLV_ADDR_W)
   ) request_fsm_i (
      .clk         (clk),
      .resetn      (resetn),
      .abm0_addr   (abm0_addr),
      .abm1_addr   (abm1_addr),
      .s_araddr    (s_axi_araddr),
      .s_arlen     (s_axi_arlen),
      .s_arvalid   (s_axi_arvalid),
      .s_arready   (s_axi_arready),
      .m_araddr    (m_axi_araddr),
      .m_arlen     (m_axi_arlen),
      .m_arvalid   (m_axi_arvalid),
      .m_arready   (m_axi_arready),
      .all_fetched (all_fetched),
      .begin_burst (begin_burst)
   );

   //==================================================
   // Data side
   //==================================================
   labm_burst_tracker burst_tracker_i (
      .clk         (clk),
      .resetn      (resetn),
      .begin_burst (begin_burst),
      .beats       (rd_beats.monitor),
      .fifo_sel    (fifo_sel),
      .all_fetched (all_fetched)
   );

   labm_read_merge #(
      .DATA_W     (DATA_W),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) read_merge_i (
      .clk      (clk),
      .resetn   (resetn),
      .beats    (rd_beats.sink),
      .fifo_sel (fifo_sel),
      .s_rdata  (s_axi_rdata),
      .s_rlast  (s_axi_rlast),
      .s_rvalid (s_axi_rvalid),
      .s_rready (s_axi_rready)
   );

endmodule

`default_nettype wire

/* tests/labm_manager_assertions.sv */
/*
   Concurrent assertions bound into the ABM manager
   - Master AR request held stable until ARREADY
   - Slave R beat held stable while RREADY is low
   - No slave acceptance while a master request is pending
*/

`timescale 1ns/100ps
`default_nettype none

module labm_manager_assertions import labm_pkg::*; #(
   parameter int DATA_W = 32
) (
   input wire               clk,
   input wire               resetn,
   input wire               s_axi_arready,
   input wire [DATA_W-1:0]  s_axi_rdata,
   input wire               s_axi_rvalid,
   input wire               s_axi_rready,
   input labm_host_addr_t   m_axi_araddr,
   input labm_len_t         m_axi_arlen,
   input wire               m_axi_arvalid,
   input wire               m_axi_arready
);

   // Number of assertion failures, read by the testbench at the end
   int assert_failures = 0;

   // A waiting master request keeps its address and length
   ar_stable: assert property (@(posedge clk) disable iff (!resetn)
      m_axi_arvalid && !m_axi_arready |=>
         m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen))
   else begin
      assert_failures++;
      $error("Master AR request changed before ARREADY");
   end

   // Both FIFO heads hold while the slave side is stalled
   r_stable: assert property (@(posedge clk) disable iff (!resetn)
      s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
   else begin
      assert_failures++;
      $error("Slave R beat changed while RREADY was low");
   end

   ar_exclusive: assert property (@(posedge clk) disable iff (!resetn)
      m_axi_arvalid |-> !s_axi_arready)
   else begin
      assert_failures++;
      $error("Slave ARREADY high while a master request is pending");
   end

endmodule

`default_nettype wire

/* tests/labm_manager_tb.sv */
/*
   Testbench of the ABM manager
   - Clock, reset and slave requests with random offsets and lengths
   - Host-memory responder on the master AR and R channels
   - Model of the ORed slave beats and typed compare tasks
   - Closing line with the error counts
*/

`timescale 1ns/100ps
`default_nettype none

module labm_manager_tb import labm_pkg::*; ();

   localparam int DATA_W     = 32;
   localparam int SLV_ADDR_W = 20;
   localparam int FIFO_DEPTH = 16;
   localparam int N_REQ      = 42;
   localparam int TIMEOUT    = 2000;

   logic                   clk = 1'b0;
   logic                   resetn;
   labm_host_addr_t        abm0_addr;
   labm_host_addr_t        abm1_addr;
   logic [SLV_ADDR_W-1:0]  s_axi_araddr;
   labm_len_t              s_axi_arlen;
   logic                   s_axi_arvalid;
   logic                   s_axi_arready;
   logic [DATA_W-1:0]      s_axi_rdata;
   logic [1:0]             s_axi_rresp;
   logic                   s_axi_rlast;
   logic                   s_axi_rvalid;
   logic                   s_axi_rready;
   labm_host_addr_t        m_axi_araddr;
   labm_len_t              m_axi_arlen;
   logic                   m_axi_arvalid;
   logic                   m_axi_arready;
   logic [DATA_W-1:0]      m_axi_rdata;
   logic                   m_axi_rlast;
   logic                   m_axi_rvalid;
   logic                   m_axi_rready;

   integer seed;
   int     mismatches = 0;
   int     proto_errors = 0;
   int     timeouts = 0;
   // Master beats moved so far, and those owed for all accepted requests
   int     m_beats_done = 0;
   int     m_beats_owed = 0;
   int     s_beats_got = 0;
   bit     active;
   bit     r_held;
   int     beat_idx = 0;

   logic [SLV_ADDR_W-1:0] req_off [N_REQ];
   labm_len_t             req_len [N_REQ];

   // Expected master requests, accepted bursts and expected slave beats
   labm_host_addr_t   exp_m_addr [$];
   labm_len_t         exp_m_len [$];
   labm_host_addr_t   burst_addr [$];
   labm_len_t         burst_len [$];
   logic [DATA_W-1:0] exp_s_data [$];
   logic              exp_s_last [$];

   always #20 clk = ~clk;

   labm_manager #(
      .DATA_W     (DATA_W),
      .SLV_ADDR_W (SLV_ADDR_W),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) dut_i (.*);

   bind labm_manager labm_manager_assertions #(.DATA_W(DATA_W)) assertions_i (
      .clk           (clk),
      .resetn        (resetn),
      .s_axi_arready (s_axi_arready),
      .s_axi_rdata   (s_axi_rdata),
      .s_axi_rvalid  (s_axi_rvalid),
      .s_axi_rready  (s_axi_rready),
      .m_axi_araddr  (m_axi_araddr),
      .m_axi_arlen   (m_axi_arlen),
      .m_axi_arvalid (m_axi_arvalid),
      .m_axi_arready (m_axi_arready)
   );

   //==================================================
   // Host memory and compare tasks
   //==================================================
   // The word stored at a byte address is the address folded, XORed and rotated
   function automatic logic [DATA_W-1:0] host_word(input labm_host_addr_t addr);
      logic [31:0] mixed;
      mixed = addr[31:0] ^ addr[63:32] ^ 32'h6c8e_35d1;
      return {mixed[24:0], mixed[31:25]};
   endfunction

   task automatic check_addr(input string name, input labm_host_addr_t exp,
                             input labm_host_addr_t act);
      if (exp !== act) begin
         mismatches++;
         $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_len(input string name, input labm_len_t exp, input labm_len_t act);
      if (exp !== act) begin
         mismatches++;
         $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      if (exp !== act) begin
         mismatches++;
         $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         mismatches++;
         $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // An accepted slave request owes two master requests and len+1 ORed beats
   task automatic record_request(input logic [SLV_ADDR_W-1:0] addr, input labm_len_t len);
      labm_host_addr_t off;
      labm_host_addr_t step;
      int k;
      off = labm_host_addr_t'(addr);
      if (m_beats_done != m_beats_owed) begin
         proto_errors++;
         $display("Slave request taken after only %0d of %0d earlier master beats",
                  m_beats_done, m_beats_owed);
      end
      m_beats_owed += 2 * (int'(len) + 1);
      exp_m_addr.push_back(abm0_addr + off);
      exp_m_addr.push_back(abm1_addr + off);
      exp_m_len.push_back(len);
      exp_m_len.push_back(len);
      for (k = 0; k <= int'(len); k++) begin
         step = labm_host_addr_t'(4 * k);
         exp_s_data.push_back(host_word(abm0_addr + off + step) |
                              host_word(abm1_addr + off + step));
         exp_s_last.push_back(k == int'(len));
      end
   endtask

   //==================================================
   // Responder and monitors
   //==================================================
   // Handshakes are sampled on the edge and new inputs follow 2 ns later
   always @(posedge clk) begin
      active = resetn;
      if (active) begin
         if (s_axi_arvalid && s_axi_arready) begin
            record_request(s_axi_araddr, s_axi_arlen);
         end
         if (m_axi_arvalid && m_axi_arready) begin
            if (exp_m_addr.size() == 0) begin
               proto_errors++;
               $display("Master request at %h with no slave request behind it", m_axi_araddr);
            end else begin
               check_addr("master araddr", exp_m_addr.pop_front(), m_axi_araddr);
               check_len("master arlen", exp_m_len.pop_front(), m_axi_arlen);
            end
            burst_addr.push_back(m_axi_araddr);
            burst_len.push_back(m_axi_arlen);
         end
         if (m_axi_rvalid && m_axi_rready) begin
            m_beats_done++;
            if (beat_idx == int'(burst_len[0])) begin
               void'(burst_addr.pop_front());
               void'(burst_len.pop_front());
               beat_idx = 0;
            end else begin
               beat_idx++;
            end
         end
         if (s_axi_rvalid && s_axi_rready) begin
            if (exp_s_data.size() == 0) begin
               proto_errors++;
               $display("Slave beat %h arrived with no beat expected", s_axi_rdata);
            end else begin
               check_word($sformatf("slave rdata beat %0d", s_beats_got),
                          exp_s_data.pop_front(), s_axi_rdata);
               check_flag($sformatf("slave rlast beat %0d", s_beats_got),
                          exp_s_last.pop_front(), s_axi_rlast);
               check_flag("slave rresp okay", 1'b1, s_axi_rresp == 2'b00);
            end
            s_beats_got++;
         end
      end
      // A raised RVALID stays up until the beat is taken
      r_held = active && m_axi_rvalid && !m_axi_rready;
      #2;
      if (active) begin
         m_axi_arready = ($random(seed) & 1) != 0;
         s_axi_rready  = ($random(seed) & 3) != 0;
         if (!r_held) begin
            if (burst_addr.size() != 0 && ($random(seed) & 3) != 0) begin
               m_axi_rvalid = 1'b1;
               m_axi_rdata  = host_word(burst_addr[0] + labm_host_addr_t'(4 * beat_idx));
               m_axi_rlast  = (beat_idx == int'(burst_len[0]));
            end else begin
               m_axi_rvalid = 1'b0;
            end
         end
      end
   end

   //==================================================
   // Main sequence
   //==================================================
   initial begin
      int i;
      int cycles;
      int total_beats;
      bit timed_out;
      seed          = 32'h0b623b97;
      timed_out     = 1'b0;
      total_beats   = 0;
      resetn        = 1'b0;
      abm0_addr     = 64'h0000_0001_2340_0000;
      abm1_addr     = 64'h0000_0002_8800_0000;
      s_axi_araddr  = '0;
      s_axi_arlen   = '0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      m_axi_arready = 1'b0;
      m_axi_rdata   = '0;
      m_axi_rlast   = 1'b0;
      m_axi_rvalid  = 1'b0;
      // Two back-to-back directed requests, then random word-aligned ones
      req_off[0] = 20'h00100;
      req_len[0] = 8'd15;
      req_off[1] = 20'h00440;
      req_len[1] = 8'd3;
      for (i = 2; i < N_REQ; i++) begin
         req_off[i] = SLV_ADDR_W'($random(seed) & 32'h000f_fffc);
         req_len[i] = labm_len_t'($random(seed) & 15);
      end
      for (i = 0; i < N_REQ; i++) begin
         total_beats += int'(req_len[i]) + 1;
      end
      repeat (8) @(posedge clk);
      #2;
      resetn = 1'b1;
      @(posedge clk);
      check_flag("reset s_rvalid", 1'b0, s_axi_rvalid);
      check_flag("reset m_arvalid", 1'b0, m_axi_arvalid);
      check_flag("reset s_arready", 1'b1, s_axi_arready);
      #2;
      // ARVALID stays high, so an early acceptance would be seen at once
      for (i = 0; i < N_REQ && !timed_out; i++) begin
         s_axi_araddr  = req_off[i];
         s_axi_arlen   = req_len[i];
         s_axi_arvalid = 1'b1;
         cycles = 0;
         do begin
            @(posedge clk);
            cycles++;
         end while (!s_axi_arready && cycles < TIMEOUT);
         if (!s_axi_arready) begin
            timeouts++;
            timed_out = 1'b1;
            $display("Request %0d was not accepted within %0d cycles", i, TIMEOUT);
         end
         #2;
      end
      s_axi_arvalid = 1'b0;
      cycles = 0;
      while (!timed_out && s_beats_got < total_beats && cycles < TIMEOUT) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!timed_out && s_beats_got < total_beats) begin
         timeouts++;
         $display("Only %0d of %0d slave beats arrived in time", s_beats_got, total_beats);
      end
      // Idle cycles in which a repeated beat would show up
      repeat (10) @(posedge clk);
      if (exp_s_data.size() != 0 || exp_m_addr.size() != 0 || burst_addr.size() != 0) begin
         proto_errors++;
         $display("Beats or requests left over at the end of the run");
      end
      $display("Closing: %0d mismatches, %0d protocol errors, %0d timeouts, %0d assertion fails",
               mismatches, proto_errors, timeouts, dut_i.assertions_i.assert_failures);
      if (mismatches + proto_errors + timeouts + dut_i.assertions_i.assert_failures == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
hdl/labm_pkg.sv
hdl/labm_beat_if.sv
hdl/labm_beat_fifo.sv
hdl/labm_burst_tracker.sv
hdl/labm_request_fsm.sv
hdl/labm_read_merge.sv
hdl/labm_manager.sv
tests/labm_manager_assertions.sv
tests/labm_manager_tb.sv

/* Bender.yml */
package:
  name: labm_manager

sources:
  - files:
      - hdl/labm_pkg.sv
      - hdl/labm_beat_if.sv
      - hdl/labm_beat_fifo.sv
      - hdl/labm_burst_tracker.sv
      - hdl/labm_request_fsm.sv
      - hdl/labm_read_merge.sv
      - hdl/labm_manager.sv
  - target: test
    files:
      - tests/labm_manager_assertions.sv
      - tests/labm_manager_tb.sv
